//--- project.f
+incdir+.
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_operand_select.sv
hw/rv_execute.sv
hw/rv_core.sv
hw/rv_soc.sv
sim/rv_soc_assert.sv
sim/rv_soc_tb.sv

//--- Bender.yml
package:
  name: rv_soc

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - hw/rv_pkg.sv
      - hw/rv_decode.sv
      - hw/rv_regfile.sv
      - hw/rv_operand_select.sv
      - hw/rv_execute.sv
      - hw/rv_core.sv
      - hw/rv_soc.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - sim/rv_soc_assert.sv
      - sim/rv_soc_tb.sv

//--- sim/rv_soc_tb.sv
`include "rv_consts.svh"

module rv_soc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {
        k_add, k_sub, k_and, k_or, k_xor, k_slt, k_addi,
        k_lui, k_chain, k_mem, k_beq, k_bne, k_jal
    } kind_e;

    // rnd rows replace a and b with xorshift values and derive the result
    typedef struct {
        string       name;
        kind_e       kind;
        bit          rnd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
    } row_t;

    localparam int NUM_ROWS = 25;

    row_t rows [NUM_ROWS] = '{
        '{"add",          k_add,   1'b0, 32'h1234_5678, 32'h0fed_cba9, 32'h2222_2221},
        '{"sub",          k_sub,   1'b0, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe},
        '{"and",          k_and,   1'b0, 32'hf0f0_ff00, 32'h3c3c_0ff0, 32'h3030_0f00},
        '{"or",           k_or,    1'b0, 32'hf0f0_ff00, 32'h3c3c_0ff0, 32'hfcfc_fff0},
        '{"xor",          k_xor,   1'b0, 32'hf0f0_ff00, 32'h3c3c_0ff0, 32'hcccc_f0f0},
        '{"slt_neg",      k_slt,   1'b0, 32'h8000_0000, 32'h0000_0001, 32'h0000_0001},
        '{"slt_pos",      k_slt,   1'b0, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0000},
        '{"addi_neg",     k_addi,  1'b0, 32'h0000_0800, 32'h0000_1000, 32'h0000_0800},
        '{"addi_pos",     k_addi,  1'b0, 32'h0000_07ff, 32'h0000_0000, 32'h0000_07ff},
        '{"lui",          k_lui,   1'b0, 32'habcd_e123, 32'h0000_0000, 32'habcd_e000},
        '{"chain",        k_chain, 1'b0, 32'h0000_0010, 32'h0000_0003, 32'hffff_fff0},
        '{"sw_lw",        k_mem,   1'b0, 32'hdead_beef, 32'h0000_0040, 32'hdead_beef},
        '{"beq_taken",    k_beq,   1'b0, 32'h0000_0055, 32'h0000_0055, 32'h0000_0011},
        '{"beq_not",      k_beq,   1'b0, 32'h0000_0055, 32'h0000_0056, 32'h0000_0311},
        '{"bne_taken",    k_bne,   1'b0, 32'h0000_0055, 32'h0000_0056, 32'h0000_0011},
        '{"bne_not",      k_bne,   1'b0, 32'h0000_0077, 32'h0000_0077, 32'h0000_0311},
        '{"jal",          k_jal,   1'b0, 32'h0000_0100, 32'h0000_0000, 32'h0000_010c},
        '{"add_rand",     k_add,   1'b1, 32'h0,         32'h0,         32'h0},
        '{"sub_rand",     k_sub,   1'b1, 32'h0,         32'h0,         32'h0},
        '{"xor_rand",     k_xor,   1'b1, 32'h0,         32'h0,         32'h0},
        '{"slt_rand",     k_slt,   1'b1, 32'h0,         32'h0,         32'h0},
        '{"addi_rand",    k_addi,  1'b1, 32'h0,         32'h0,         32'h0},
        '{"lui_rand",     k_lui,   1'b1, 32'h0,         32'h0,         32'h0},
        '{"chain_rand",   k_chain, 1'b1, 32'h0,         32'h0,         32'h0},
        '{"sw_lw_rand",   k_mem,   1'b1, 32'h0,         32'h0,         32'h0}
    };

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   prog_we;
    logic [`RV_IMEM_AW-1:0] prog_addr;
    rv_pkg::inst_t          prog_data;
    logic                   exit;
    rv_pkg::word_t          gp;

    logic [31:0] prog [$];
    logic [31:0] rng_state;

    rv_soc rv_soc_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .exit      (exit),
        .gp        (gp)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // result that gp must hold for each program shape
    function automatic logic [31:0] expected_for(input kind_e kind, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic [31:0] sum;
        logic [31:0] result;
        sum = a + b;
        case (kind)
            k_add:   result = a + b;
            k_sub:   result = a - b;
            k_and:   result = a & b;
            k_or:    result = a | b;
            k_xor:   result = a ^ b;
            k_slt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            k_addi:  result = b + {{20{a[11]}}, a[11:0]};
            k_lui:   result = {a[31:12], 12'h000};
            k_chain: result = (sum ^ a) - sum;
            k_mem:   result = a;
            k_beq:   result = (a == b) ? 32'h11 : 32'h311;
            k_bne:   result = (a != b) ? 32'h11 : 32'h311;
            // link of the jal at byte 8
            k_jal:   result = a + 32'd12;
            default: result = '0;
        endcase
        return result;
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // always two words, lui then addi
    task automatic load_imm(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(u_type(upper[31:12], rd));
        emit(i_type(value[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic alu_program(input logic [6:0] f7, input logic [2:0] f3,
                               input logic [31:0] a, input logic [31:0] b);
        load_imm(5'd1, a);
        load_imm(5'd2, b);
        emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
    endtask

    task automatic branch_program(input logic [2:0] f3, input logic [31:0] a,
                                  input logic [31:0] b);
        emit(i_type(12'h010, 5'd0, 3'b000, 5'd3, 7'b0010011));
        load_imm(5'd1, a);
        load_imm(5'd2, b);
        emit(b_type(13'd12, 5'd2, 5'd1, f3));
        // wrong path words
        emit(i_type(12'h100, 5'd3, 3'b000, 5'd3, 7'b0010011));
        emit(i_type(12'h200, 5'd3, 3'b000, 5'd3, 7'b0010011));
        emit(i_type(12'h001, 5'd3, 3'b000, 5'd3, 7'b0010011));
    endtask

    task automatic build_program(input kind_e kind, input logic [31:0] a,
                                 input logic [31:0] b);
        prog.delete();
        case (kind)
            k_add:   alu_program(7'h00, 3'b000, a, b);
            k_sub:   alu_program(7'h20, 3'b000, a, b);
            k_and:   alu_program(7'h00, 3'b111, a, b);
            k_or:    alu_program(7'h00, 3'b110, a, b);
            k_xor:   alu_program(7'h00, 3'b100, a, b);
            k_slt:   alu_program(7'h00, 3'b010, a, b);
            k_addi: begin
                load_imm(5'd1, b);
                emit(i_type(a[11:0], 5'd1, 3'b000, 5'd3, 7'b0010011));
            end
            k_lui:   emit(u_type(a[31:12], 5'd3));
            k_chain: begin
                load_imm(5'd1, a);
                load_imm(5'd2, b);
                emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
                emit(r_type(7'h00, 5'd1, 5'd4, 3'b100, 5'd5));
                emit(r_type(7'h20, 5'd4, 5'd5, 3'b000, 5'd3));
            end
            k_mem: begin
                load_imm(5'd1, a);
                load_imm(5'd2, b & 32'h0000_00fc);
                emit(s_type(12'd0, 5'd1, 5'd2));
                emit(i_type(12'd0, 5'd2, 3'b010, 5'd4, 7'b0000011));
                // consumer right behind the load
                emit(r_type(7'h00, 5'd0, 5'd4, 3'b000, 5'd3));
            end
            k_beq:   branch_program(3'b000, a, b);
            k_bne:   branch_program(3'b001, a, b);
            k_jal: begin
                load_imm(5'd3, a);
                emit(j_type(21'd12, 5'd5));
                emit(i_type(12'h100, 5'd3, 3'b000, 5'd3, 7'b0010011));
                emit(i_type(12'h200, 5'd3, 3'b000, 5'd3, 7'b0010011));
                emit(r_type(7'h00, 5'd5, 5'd3, 3'b000, 5'd3));
            end
            default: begin
            end
        endcase
        emit(32'h0000_0073);
        // these must never reach gp
        repeat (4) begin
            emit(i_type(12'h7ab, 5'd0, 3'b000, 5'd3, 7'b0010011));
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // reset stays low through the load and for 3 cycles after it
    task automatic program_and_reset();
        @(negedge clk);
        rst_n = 1'b0;
        foreach (prog[i]) begin
            prog_we   = 1'b1;
            prog_addr = `RV_IMEM_AW'(i);
            prog_data = prog[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic run_row(input int idx);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        int          limit;
        int          cycles;
        a        = rows[idx].a;
        b        = rows[idx].b;
        expected = rows[idx].expected;
        if (rows[idx].rnd) begin
            rng_state = xorshift(rng_state);
            a         = rng_state;
            rng_state = xorshift(rng_state);
            b         = rng_state;
            expected  = expected_for(rows[idx].kind, a, b);
        end
        build_program(rows[idx].kind, a, b);
        program_and_reset();
        limit  = 8 * prog.size() + 20;
        cycles = 0;
        @(negedge clk);
        check({rows[idx].name, " exit after reset"}, 32'd0, {31'b0, exit});
        while (exit !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: %s did not raise exit within %0d cycles",
                         rows[idx].name, limit);
                $display(">>> FAIL");
                $fatal(1, "timeout");
            end
        end
        check(rows[idx].name, expected, gp);
        repeat (10) begin
            @(negedge clk);
            check({rows[idx].name, " exit held"}, 32'd1, {31'b0, exit});
            check({rows[idx].name, " gp held"}, expected, gp);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        rng_state = 32'd53;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- sim/rv_soc_assert.sv
module rv_soc_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        exit,
    input logic        dmem_we,
    input logic        stall_id,
    input rv_pkg::pc_t pc
);

    timeunit 1ns;
    timeprecision 1ps;

    // exit is sticky until the next reset
    exit_sticky: assert property (
        @(posedge clk) (rst_n && $past(rst_n) && $past(exit)) |-> exit
    ) else $error("exit fell while the core was out of reset");

    // once reset has been seen on an edge the memory stage is empty
    no_store_in_reset: assert property (
        @(posedge clk) (!rst_n && $past(!rst_n)) |-> !dmem_we
    ) else $error("data RAM write strobe high during reset");

    // a load-use stall keeps the fetch address
    pc_holds_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall_id |=> (pc == $past(pc))
    ) else $error("pc moved while stall_id was high");

endmodule

bind rv_core rv_soc_assert u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .exit     (exit),
    .dmem_we  (dmem_we),
    .stall_id (stall_id),
    .pc       (pc)
);

//--- hw/rv_soc.sv
`include "rv_consts.svh"

module rv_soc (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   prog_we,
    input  logic [`RV_IMEM_AW-1:0] prog_addr,
    input  rv_pkg::inst_t          prog_data,
    output logic                   exit,
    output rv_pkg::word_t          gp
);

    rv_pkg::inst_t imem [`RV_IMEM_WORDS];
    rv_pkg::word_t dmem [`RV_DMEM_WORDS];

    rv_pkg::pc_t   imem_addr;
    rv_pkg::inst_t imem_inst;
    rv_pkg::pc_t   dmem_addr;
    logic          dmem_we;
    rv_pkg::word_t dmem_wdata;
    rv_pkg::word_t dmem_rdata;

    logic [`RV_IMEM_AW-1:0]            imem_idx;
    logic [$clog2(`RV_DMEM_WORDS)-1:0] dmem_idx;

    // both RAMs are word addressed
    assign imem_idx = imem_addr[`RV_IMEM_AW+1:2];
    assign dmem_idx = dmem_addr[$clog2(`RV_DMEM_WORDS)+1:2];

    // program load port stays live through reset
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
        imem_inst <= imem[imem_idx];
    end

    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_idx] <= dmem_wdata;
        end
        dmem_rdata <= dmem[dmem_idx];
    end

    rv_core u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_inst  (imem_inst),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wdata (dmem_wdata),
        .exit       (exit),
        .gp         (gp)
    );

endmodule

//--- hw/rv_core.sv
`include "rv_consts.svh"

module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::inst_t imem_inst,
    input  rv_pkg::word_t dmem_rdata,
    output rv_pkg::pc_t   imem_addr,
    output rv_pkg::pc_t   dmem_addr,
    output logic          dmem_we,
    output rv_pkg::word_t dmem_wdata,
    output logic          exit,
    output rv_pkg::word_t gp
);

    rv_pkg::pc_t pc;
    logic        stall_id;
    logic        flush;
    logic        exit_r;

    // decode stage, the instruction word is the RAM output itself
    logic              id_valid;
    rv_pkg::pc_t       id_pc;
    rv_pkg::reg_addr_t d_rs1;
    rv_pkg::reg_addr_t d_rs2;
    rv_pkg::reg_addr_t d_rd;
    rv_pkg::word_t     d_imm;
    rv_pkg::alu_op_e   d_alu_op;
    logic              d_use_imm;
    logic              d_reg_we;
    logic              d_mem_rd;
    logic              d_mem_wr;
    rv_pkg::wb_sel_e   d_wb_sel;
    rv_pkg::br_kind_e  d_br_kind;
    logic              d_is_ecall;

    // execute stage
    logic              ex_valid;
    rv_pkg::pc_t       ex_pc;
    rv_pkg::reg_addr_t ex_rs1;
    rv_pkg::reg_addr_t ex_rs2;
    rv_pkg::reg_addr_t ex_rd;
    rv_pkg::word_t     ex_imm;
    rv_pkg::alu_op_e   ex_alu_op;
    logic              ex_use_imm;
    logic              ex_reg_we;
    logic              ex_mem_rd;
    logic              ex_mem_wr;
    rv_pkg::wb_sel_e   ex_wb_sel;
    rv_pkg::br_kind_e  ex_br_kind;
    logic              ex_is_ecall;
    rv_pkg::word_t     rf_rd1;
    rv_pkg::word_t     rf_rd2;
    rv_pkg::word_t     op_a;
    rv_pkg::word_t     op_b;
    rv_pkg::word_t     ex_result;
    logic              ex_taken;
    rv_pkg::pc_t       ex_target;

    // memory stage
    logic              mem_valid;
    rv_pkg::pc_t       mem_pc;
    rv_pkg::reg_addr_t mem_rd;
    rv_pkg::word_t     mem_result;
    rv_pkg::word_t     mem_store;
    logic              mem_reg_we;
    logic              mem_is_load;
    logic              mem_wr;
    rv_pkg::wb_sel_e   mem_wb_sel;
    logic              mem_is_ecall;
    rv_pkg::word_t     mem_value;

    // writeback stage
    logic              wb_valid;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t     wb_data;
    logic              wb_reg_we;
    rv_pkg::wb_sel_e   wb_wb_sel;
    logic              wb_is_ecall;
    rv_pkg::word_t     wb_value;

    rv_decode u_decode (
        .inst     (imem_inst),
        .rs1      (d_rs1),
        .rs2      (d_rs2),
        .rd       (d_rd),
        .imm      (d_imm),
        .alu_op   (d_alu_op),
        .use_imm  (d_use_imm),
        .reg_we   (d_reg_we),
        .mem_rd   (d_mem_rd),
        .mem_wr   (d_mem_wr),
        .wb_sel   (d_wb_sel),
        .br_kind  (d_br_kind),
        .is_ecall (d_is_ecall)
    );

    // nothing is written once the program has exited
    rv_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (ex_rs1),
        .ra2   (ex_rs2),
        .wa    (wb_rd),
        .we    (wb_valid && wb_reg_we && !exit_r),
        .wd    (wb_value),
        .rd1   (rf_rd1),
        .rd2   (rf_rd2),
        .gp    (gp)
    );

    // operands are resolved for the instruction in execute, so the
    // hazard check looks at a load sitting in the memory stage
    rv_operand_select u_operand_select (
        .rs1         (ex_rs1),
        .rs2         (ex_rs2),
        .rd1         (rf_rd1),
        .rd2         (rf_rd2),
        .ex_valid    (ex_valid && mem_valid),
        .ex_mem_rd   (mem_is_load),
        .ex_rd       (mem_rd),
        .mem_valid   (mem_valid),
        .mem_reg_we  (mem_reg_we),
        .mem_is_load (mem_is_load),
        .mem_rd      (mem_rd),
        .mem_value   (mem_value),
        .wb_valid    (wb_valid),
        .wb_reg_we   (wb_reg_we),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .op_a        (op_a),
        .op_b        (op_b),
        .load_use    (stall_id)
    );

    rv_execute u_execute (
        .pc      (ex_pc),
        .op_a    (op_a),
        .op_b    (op_b),
        .imm     (ex_imm),
        .alu_op  (ex_alu_op),
        .use_imm (ex_use_imm),
        .br_kind (ex_br_kind),
        .result  (ex_result),
        .taken   (ex_taken),
        .target  (ex_target)
    );

    // a stalled branch still sees stale operands
    assign flush = ex_valid && ex_taken && !stall_id;

    // refetch the decode word while stalled so the RAM output holds
    assign imem_addr = stall_id ? id_pc : pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= `RV_RESET_PC;
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
            exit_r    <= 1'b0;
        end else begin
            if (exit_r) begin
                id_valid <= 1'b0;
            end else if (flush) begin
                pc       <= ex_target;
                id_valid <= 1'b0;
            end else if (!stall_id) begin
                pc       <= pc + 32'd4;
                id_valid <= 1'b1;
            end
            if (flush) begin
                ex_valid <= 1'b0;
            end else if (!stall_id) begin
                ex_valid <= id_valid;
            end
            mem_valid <= ex_valid && !stall_id;
            wb_valid  <= mem_valid;
            if (wb_valid && wb_is_ecall) begin
                exit_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_id) begin
            id_pc       <= pc;
            ex_pc       <= id_pc;
            ex_rs1      <= d_rs1;
            ex_rs2      <= d_rs2;
            ex_rd       <= d_rd;
            ex_imm      <= d_imm;
            ex_alu_op   <= d_alu_op;
            ex_use_imm  <= d_use_imm;
            ex_reg_we   <= d_reg_we;
            ex_mem_rd   <= d_mem_rd;
            ex_mem_wr   <= d_mem_wr;
            ex_wb_sel   <= d_wb_sel;
            ex_br_kind  <= d_br_kind;
            ex_is_ecall <= d_is_ecall;
        end
        mem_pc       <= ex_pc;
        mem_rd       <= ex_rd;
        mem_result   <= ex_result;
        mem_store    <= op_b;
        mem_reg_we   <= ex_reg_we;
        mem_is_load  <= ex_mem_rd;
        mem_wr       <= ex_mem_wr;
        mem_wb_sel   <= ex_wb_sel;
        mem_is_ecall <= ex_is_ecall;
        wb_rd        <= mem_rd;
        wb_data      <= mem_value;
        wb_reg_we    <= mem_reg_we;
        wb_wb_sel    <= mem_wb_sel;
        wb_is_ecall  <= mem_is_ecall;
    end

    // data RAM access from the memory stage
    assign dmem_addr  = mem_result;
    assign dmem_we    = mem_valid && mem_wr && !exit_r;
    assign dmem_wdata = mem_store;

    assign mem_value = (mem_wb_sel == rv_pkg::wb_pc4) ? mem_pc + 32'd4 : mem_result;
    assign wb_value  = (wb_wb_sel == rv_pkg::wb_mem) ? dmem_rdata : wb_data;

    assign exit = exit_r;

endmodule

//--- hw/rv_execute.sv
module rv_execute (
    input  rv_pkg::pc_t      pc,
    input  rv_pkg::word_t    op_a,
    input  rv_pkg::word_t    op_b,
    input  rv_pkg::word_t    imm,
    input  rv_pkg::alu_op_e  alu_op,
    input  logic             use_imm,
    input  rv_pkg::br_kind_e br_kind,
    output rv_pkg::word_t    result,
    output logic             taken,
    output rv_pkg::pc_t      target
);

    rv_pkg::word_t b;

    assign b = use_imm ? imm : op_b;

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add:    result = op_a + b;
            rv_pkg::alu_sub:    result = op_a - b;
            rv_pkg::alu_and:    result = op_a & b;
            rv_pkg::alu_or:     result = op_a | b;
            rv_pkg::alu_xor:    result = op_a ^ b;
            rv_pkg::alu_slt:    result = {31'b0, $signed(op_a) < $signed(b)};
            rv_pkg::alu_pass_b: result = b;
            default:            result = op_a + b;
        endcase
    end

    // branches compare the two registers, never the immediate
    always_comb begin
        case (br_kind)
            rv_pkg::br_beq: taken = (op_a == op_b);
            rv_pkg::br_bne: taken = (op_a != op_b);
            rv_pkg::br_jal: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    assign target = pc + imm;

endmodule

//--- hw/rv_operand_select.sv
module rv_operand_select (
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::word_t     rd1,
    input  rv_pkg::word_t     rd2,
    input  logic              ex_valid,
    input  logic              ex_mem_rd,
    input  rv_pkg::reg_addr_t ex_rd,
    input  logic              mem_valid,
    input  logic              mem_reg_we,
    input  logic              mem_is_load,
    input  rv_pkg::reg_addr_t mem_rd,
    input  rv_pkg::word_t     mem_value,
    input  logic              wb_valid,
    input  logic              wb_reg_we,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_value,
    output rv_pkg::word_t     op_a,
    output rv_pkg::word_t     op_b,
    output logic              load_use
);

    logic mem_fwd_ok;
    logic wb_fwd_ok;

    // a load result is not ready until writeback
    assign mem_fwd_ok = mem_valid && mem_reg_we && !mem_is_load && mem_rd != 5'd0;
    assign wb_fwd_ok  = wb_valid && wb_reg_we && wb_rd != 5'd0;

    function automatic rv_pkg::word_t pick(input rv_pkg::reg_addr_t rs,
                                           input rv_pkg::word_t     rf_value);
        rv_pkg::word_t value;
        value = rf_value;
        if (rs == 5'd0) begin
            value = '0;
        end else if (mem_fwd_ok && mem_rd == rs) begin
            value = mem_value;
        end else if (wb_fwd_ok && wb_rd == rs) begin
            value = wb_value;
        end
        return value;
    endfunction

    assign op_a = pick(rs1, rd1);
    assign op_b = pick(rs2, rd2);

    // pending load one stage ahead of the consumer
    assign load_use = ex_valid && ex_mem_rd && ex_rd != 5'd0 &&
                      (ex_rd == rs1 || ex_rd == rs2);

endmodule

//--- hw/rv_regfile.sv
module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t ra1,
    input  rv_pkg::reg_addr_t ra2,
    input  rv_pkg::reg_addr_t wa,
    input  logic              we,
    input  rv_pkg::word_t     wd,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2,
    output rv_pkg::word_t     gp
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

    // x3 is watched by the testbench
    assign gp = regs[3];

endmodule

//--- hw/rv_decode.sv
module rv_decode (
    input  rv_pkg::inst_t     inst,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::word_t     imm,
    output rv_pkg::alu_op_e   alu_op,
    output logic              use_imm,
    output logic              reg_we,
    output logic              mem_rd,
    output logic              mem_wr,
    output rv_pkg::wb_sel_e   wb_sel,
    output rv_pkg::br_kind_e  br_kind,
    output logic              is_ecall
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // register fields sit at fixed positions for every format
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    always_comb begin
        // default is a bubble that writes nothing
        imm      = '0;
        alu_op   = rv_pkg::alu_add;
        use_imm  = 1'b0;
        reg_we   = 1'b0;
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        wb_sel   = rv_pkg::wb_alu;
        br_kind  = rv_pkg::br_none;
        is_ecall = 1'b0;
        case (opcode)
            7'b0110011: begin
                reg_we = 1'b1;
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b010:  alu_op = rv_pkg::alu_slt;
                    3'b100:  alu_op = rv_pkg::alu_xor;
                    3'b110:  alu_op = rv_pkg::alu_or;
                    3'b111:  alu_op = rv_pkg::alu_and;
                    default: reg_we = 1'b0;
                endcase
            end
            7'b0010011: begin
                // only addi of the OP-IMM group
                imm     = {{20{inst[31]}}, inst[31:20]};
                use_imm = 1'b1;
                reg_we  = (funct3 == 3'b000);
            end
            7'b0110111: begin
                imm     = {inst[31:12], 12'b0};
                use_imm = 1'b1;
                alu_op  = rv_pkg::alu_pass_b;
                reg_we  = 1'b1;
            end
            7'b0000011: begin
                imm     = {{20{inst[31]}}, inst[31:20]};
                use_imm = 1'b1;
                reg_we  = (funct3 == 3'b010);
                mem_rd  = (funct3 == 3'b010);
                wb_sel  = rv_pkg::wb_mem;
            end
            7'b0100011: begin
                imm     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                use_imm = 1'b1;
                mem_wr  = (funct3 == 3'b010);
            end
            7'b1100011: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                if (funct3 == 3'b000) begin
                    br_kind = rv_pkg::br_beq;
                end else if (funct3 == 3'b001) begin
                    br_kind = rv_pkg::br_bne;
                end
            end
            7'b1101111: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                br_kind = rv_pkg::br_jal;
                reg_we  = 1'b1;
                wb_sel  = rv_pkg::wb_pc4;
            end
            7'b1110011: begin
                is_ecall = (inst == 32'h0000_0073);
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

    // data word as seen by the register file and ALU
    typedef logic [31:0] word_t;

    // register index x0..x31
    typedef logic [4:0] reg_addr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // byte address of an instruction or data word
    typedef logic [31:0] pc_t;

    // ALU function, pass-b forwards the immediate for LUI
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    // source of the register writeback value
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_e;

    // control transfer kind resolved in execute
    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_jal
    } br_kind_e;

endpackage

//--- rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// instruction RAM depth in 32-bit words
`define RV_IMEM_WORDS 64

// data RAM depth in 32-bit words
`define RV_DMEM_WORDS 64

// word address width of the instruction load port
`define RV_IMEM_AW 6

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
